// File: verif/loader_testdata.txt
# test <name> <count hex> <stream position of an extra bad-stop byte, -1 none> <its value hex>
# word <instruction sent lsb byte first>    expect <word index> <word read back>
test single 01 -1 00
word 12345678
expect 0 12345678
test multi 05 -1 00
word 0badf00d
word deadbeef
word 00c0ffee
word 13579bdf
word 2468ace0
expect 0 0badf00d
expect 1 deadbeef
expect 2 00c0ffee
expect 3 13579bdf
expect 4 2468ace0
test reload 02 -1 00
word a5a5a5a5
word 5a5a5a5a
expect 0 a5a5a5a5
expect 1 5a5a5a5a
expect 2 00c0ffee
expect 3 13579bdf
test zero 00 -1 00
expect 0 a5a5a5a5
expect 1 5a5a5a5a
expect 2 00c0ffee
test after_zero 01 -1 00
word fedcba98
expect 0 fedcba98
expect 1 5a5a5a5a
test framing 03 6 c3
word 11223344
word 55667788
word 99aabbcc
expect 0 11223344
expect 1 55667788
expect 2 99aabbcc
expect 3 13579bdf

// File: all.f
hdl/loader_pkg.sv
hdl/uart_rx.sv
hdl/prog_loader.sv
hdl/prog_mem.sv
hdl/loader_top.sv
verif/loader_checker.sv
verif/loader_tb.sv

// File: verif/loader_tb.sv
`timescale 1ns/10ps
`default_nettype none

module loader_tb;

    localparam int CLKS_PER_BIT = 8;
    localparam int ADDR_W       = 10;
    localparam int FA_W         = ADDR_W - 2;   // fetch index width
    localparam int MAX_GAP      = 8;            // idle bits after a byte, 1 plus three random bits
    localparam int SETTLE       = 6;            // cycles after ready before counts are compared

    logic                          clk = 1'b0;
    logic                          arst_n;
    logic                          rx;
    logic [FA_W-1:0]               fetch_addr;
    logic [loader_pkg::WORD_W-1:0] fetch_data;
    logic                          prog_rdy;
    logic                          frame_err;

    string       t_name[$];                     // one entry per test record
    logic [7:0]  t_count[$];
    int          t_bad_pos[$];                  // stream position of an extra bad byte, -1 none
    logic [7:0]  t_bad_byte[$];
    int          t_wfirst[$];
    int          t_wnum[$];
    int          t_xfirst[$];
    int          t_xnum[$];
    logic [31:0] send_words[$];                 // words of all records, back to back
    int          exp_idx[$];
    logic [31:0] exp_word[$];

    logic [31:0] lfsr_state = 32'haef3;
    int          rdy_cnt    = 0;
    int          ferr_cnt   = 0;
    int          err_cnt    = 0;
    int          check_cnt  = 0;
    int          budget     = 0;                // watchdog limit in cycles
    int          total_err;

    loader_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .ADDR_W       (ADDR_W)
    ) loader_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .rx         (rx),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .prog_rdy   (prog_rdy),
        .frame_err  (frame_err)
    );

    always #50 clk = ~clk;                      // 100 ns period

    // pulse counters
    always @(posedge clk) begin
        if (prog_rdy) rdy_cnt <= rdy_cnt + 1;
        if (frame_err) ferr_cnt <= ferr_cnt + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // galois lfsr, one step per bit taken
    function automatic int take_bits(input int n);
        int val;
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            val        = (val << 1) | int'(lfsr_state[0]);
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'ha3000000 : 32'h0);
        end
        return val;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected 0x%h got 0x%h", sig, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = 0;
        while (c != 10 && c != -1) c = $fgetc(fd);
    endtask

    task automatic read_testdata();
        int          fd;
        int          code;
        int          last;
        int          pos;
        string       key;
        string       name;
        logic [31:0] v0;
        logic [31:0] v1;
        fd = $fopen("verif/loader_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/loader_testdata.txt");
            return;
        end
        while ($fscanf(fd, "%s", key) == 1) begin
            last = t_name.size() - 1;
            if (key.getc(0) == "#") begin
                skip_line(fd);                  // column description
            end else if (key == "test") begin
                code = $fscanf(fd, "%s %h %d %h", name, v0, pos, v1);
                if (code != 4) begin
                    $display("a test record in the data file is incomplete");
                    err_cnt++;
                end
                t_name.push_back(name);
                t_count.push_back(v0[7:0]);
                t_bad_pos.push_back(pos);
                t_bad_byte.push_back(v1[7:0]);
                t_wfirst.push_back(send_words.size());
                t_wnum.push_back(0);
                t_xfirst.push_back(exp_idx.size());
                t_xnum.push_back(0);
            end else if (key == "word" && last >= 0) begin
                code = $fscanf(fd, "%h", v0);
                if (code != 1) begin
                    $display("a word entry in the data file has no value");
                    err_cnt++;
                end
                send_words.push_back(v0);
                t_wnum[last]++;
            end else if (key == "expect" && last >= 0) begin
                code = $fscanf(fd, "%d %h", pos, v0);
                if (code != 2) begin
                    $display("an expect entry in the data file is incomplete");
                    err_cnt++;
                end
                exp_idx.push_back(pos);
                exp_word.push_back(v0);
                t_xnum[last]++;
            end else begin
                $display("unexpected entry %s in the test data file", key);
                err_cnt++;
                skip_line(fd);
            end
        end
        $fclose(fd);
    endtask

    // serial time of every byte at its longest gap, plus read-back, doubled
    function automatic int run_budget();
        int cycles;
        int nbytes;
        int t;
        cycles = 4;
        for (t = 0; t < t_name.size(); t++) begin
            nbytes = 1 + 4 * t_wnum[t] + ((t_bad_pos[t] >= 0) ? 1 : 0);
            cycles += nbytes * (10 + MAX_GAP) * CLKS_PER_BIT + 2 * t_xnum[t] + SETTLE + 2;
        end
        return 2 * cycles;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // serial stimulus and read-back
    ////////////////////////////////////////////////////////////////////////////

    task automatic hold_line(input logic level);
        @(negedge clk);
        rx = level;
        repeat (CLKS_PER_BIT - 1) @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] data, input bit bad_stop);
        int gap;
        int i;
        hold_line(1'b0);                        // start bit
        for (i = 0; i < 8; i++) hold_line(data[i]);
        hold_line(!bad_stop);
        gap = 1 + take_bits(3);                 // at least one idle bit gives a start edge
        repeat (gap) hold_line(1'b1);
    endtask

    task automatic read_word(input int idx, input logic [31:0] expected);
        @(negedge clk);
        fetch_addr = FA_W'(idx);
        @(negedge clk);                         // one clock of read latency
        check_value($sformatf("fetch_data[%0d]", idx), expected, fetch_data);
    endtask

    task automatic run_test(input int t);
        logic [7:0] stream[$];
        int         errs_before;
        int         rdy_before;
        int         ferr_before;
        int         w;
        int         b;
        int         pos;
        errs_before = err_cnt;
        rdy_before  = rdy_cnt;
        ferr_before = ferr_cnt;
        stream.push_back(t_count[t]);
        for (w = 0; w < t_wnum[t]; w++) begin
            for (b = 0; b < 4; b++) stream.push_back(send_words[t_wfirst[t] + w][8*b +: 8]);
        end
        for (pos = 0; pos < stream.size(); pos++) begin
            if (pos == t_bad_pos[t]) send_byte(t_bad_byte[t], 1'b1);
            send_byte(stream[pos], 1'b0);
        end
        while (rdy_cnt == rdy_before) @(negedge clk);
        repeat (SETTLE) @(negedge clk);
        check_value("prog_rdy pulses", 32'd1, 32'(rdy_cnt - rdy_before));
        check_value("frame_err pulses", (t_bad_pos[t] >= 0) ? 32'd1 : 32'd0,
                    32'(ferr_cnt - ferr_before));
        for (w = 0; w < t_xnum[t]; w++) begin
            read_word(exp_idx[t_xfirst[t] + w], exp_word[t_xfirst[t] + w]);
        end
        if (err_cnt == errs_before) $display("test %0s passed", t_name[t]);
        else $display("test %0s failed with %0d errors", t_name[t], err_cnt - errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        arst_n     = 1'b0;
        rx         = 1'b1;                      // line idle
        fetch_addr = '0;
        read_testdata();
        if (t_name.size() == 0) begin
            $display("no test records were read from the data file");
            err_cnt++;
        end else begin
            budget = run_budget();
            repeat (2) @(negedge clk);
            arst_n = 1'b1;
            for (int t = 0; t < t_name.size(); t++) run_test(t);
        end
        total_err = err_cnt + loader_top_i.prog_loader_i.loader_checker_i.fail_cnt;
        $display("tests %0d, checks %0d, check errors %0d, assertion errors %0d",
                 t_name.size(), check_cnt, err_cnt, total_err - err_cnt);
        if (total_err == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("timeout: the loads did not complete within %0d clock cycles", budget);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/loader_checker.sv
`timescale 1ns/10ps
`default_nettype none

module loader_checker (
    input logic                clk,
    input logic                arst_n,
    input loader_pkg::mem_wr_t mem_wr,
    input logic                prog_rdy
);

    int fail_cnt = 0;                           // failed assertions so far

    ////////////////////////////////////////////////////////////////////////////
    // strobe shape
    ////////////////////////////////////////////////////////////////////////////

    // ready comes one cycle after the last write, never with it
    rdy_not_with_wr: assert property (@(posedge clk) disable iff (!arst_n)
        !(prog_rdy && mem_wr.en))
        else begin
            fail_cnt++;
            $error("prog_rdy high during a memory write");
        end

    wr_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr.en |=> !mem_wr.en)                // loader leaves S_WRITE at once
        else begin
            fail_cnt++;
            $error("write enable held for more than one cycle");
        end

    rdy_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        prog_rdy |=> !prog_rdy)
        else begin
            fail_cnt++;
            $error("prog_rdy held for more than one cycle");
        end

    ////////////////////////////////////////////////////////////////////////////
    // address and reset
    ////////////////////////////////////////////////////////////////////////////

    wr_addr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr.addr[1:0] == 2'b00)               // byte address steps by four
        else begin
            fail_cnt++;
            $error("write address not word aligned");
        end

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!mem_wr.en && !prog_rdy))
        else begin
            fail_cnt++;
            $error("write or ready active during reset");
        end

endmodule

bind prog_loader loader_checker loader_checker_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .mem_wr   (mem_wr),
    .prog_rdy (prog_rdy)
);

`default_nettype wire

// File: hdl/loader_top.sv
`timescale 1ns/10ps
`default_nettype none

module loader_top #(
    parameter int CLKS_PER_BIT = 8,                 // serial bit time in clocks
    parameter int ADDR_W       = 10                 // program memory byte address width
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          rx,           // serial program input
    input  logic [ADDR_W-3:0]             fetch_addr,   // fetch word index
    output logic [loader_pkg::WORD_W-1:0] fetch_data,
    output logic                          prog_rdy,     // load finished
    output logic                          frame_err     // byte dropped on a bad stop bit
);

    loader_pkg::rx_byte_t rx_byte;                  // receiver to loader
    loader_pkg::mem_wr_t  mem_wr;                   // loader to memory

    ////////////////////////////////////////////////////////////////////////////
    // serial receiver
    ////////////////////////////////////////////////////////////////////////////

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_rx_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .byte_out  (rx_byte),
        .frame_err (frame_err)
    );

    ////////////////////////////////////////////////////////////////////////////
    // word assembly and write control
    ////////////////////////////////////////////////////////////////////////////

    prog_loader #(
        .ADDR_W (ADDR_W)
    ) prog_loader_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .byte_in  (rx_byte),
        .mem_wr   (mem_wr),
        .prog_rdy (prog_rdy)
    );

    ////////////////////////////////////////////////////////////////////////////
    // program memory
    ////////////////////////////////////////////////////////////////////////////

    prog_mem #(
        .ADDR_W (ADDR_W)
    ) prog_mem_i (
        .clk        (clk),
        .mem_wr     (mem_wr),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

endmodule

`default_nettype wire

// File: hdl/prog_mem.sv
`timescale 1ns/10ps
`default_nettype none

module prog_mem #(
    parameter int ADDR_W = 10                       // byte address width
) (
    input  logic                            clk,
    input  loader_pkg::mem_wr_t             mem_wr,     // write port, byte address
    input  logic [ADDR_W-3:0]               fetch_addr, // read port, word index
    output logic [loader_pkg::WORD_W-1:0]   fetch_data  // read data, one clock later
);

    localparam int DEPTH = 2 ** (ADDR_W - 2);       // one entry per word

    logic [loader_pkg::WORD_W-1:0] mem [DEPTH];
    logic [ADDR_W-3:0]             wr_idx;

    // byte address down to a word index
    assign wr_idx = mem_wr.addr[ADDR_W-1:2];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mem_wr.en) begin
            mem[wr_idx] <= mem_wr.data.word;        // whole word at once
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////////////////////

    // same-cycle write to the same index returns the old word
    always_ff @(posedge clk) begin
        fetch_data <= mem[fetch_addr];
    end

endmodule

`default_nettype wire

// File: hdl/prog_loader.sv
`timescale 1ns/10ps
`default_nettype none

module prog_loader #(
    parameter int ADDR_W = 10                       // byte address width, up to ADDR_W_MAX
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  loader_pkg::rx_byte_t byte_in,           // byte strobes from the receiver
    output loader_pkg::mem_wr_t  mem_wr,            // one write per assembled word
    output logic                 prog_rdy           // one-cycle pulse when the load ends
);

    localparam int LANE_W = $clog2(loader_pkg::BYTES_PER_WORD);

    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(loader_pkg::BYTES_PER_WORD - 1);
    localparam logic [ADDR_W-1:0] ADDR_STEP = ADDR_W'(loader_pkg::BYTES_PER_WORD);

    // lane states are consecutive so the lane index falls out of the state
    typedef enum logic [2:0] {
        S_WAIT_CNT = 3'd0,  // next byte is the instruction count
        S_LANE0    = 3'd1,
        S_LANE1    = 3'd2,
        S_LANE2    = 3'd3,
        S_LANE3    = 3'd4,
        S_WRITE    = 3'd5,  // word complete, write it
        S_DONE     = 3'd6   // load finished
    } ld_state_t;

    ld_state_t                         state;
    ld_state_t                         state_next;
    logic [loader_pkg::BYTE_W-1:0]     remain;      // instructions still to write
    logic [loader_pkg::BYTE_W-1:0]     remain_next;
    logic [ADDR_W-1:0]                 addr;        // byte address of the current word
    logic [ADDR_W-1:0]                 addr_next;
    loader_pkg::instr_word_u           word;        // word under assembly
    loader_pkg::instr_word_u           word_next;
    logic [LANE_W-1:0]                 lane_sel;
    logic [loader_pkg::ADDR_W_MAX-1:0] addr_ext;

    assign lane_sel = LANE_W'(state - S_LANE0);     // only meaningful in lane states

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next  = state;
        remain_next = remain;
        addr_next   = addr;
        word_next   = word;
        case (state)
            S_WAIT_CNT: begin
                if (byte_in.valid) begin
                    remain_next = byte_in.data;
                    // a zero count ends the load at once
                    state_next  = (byte_in.data == '0) ? S_DONE : S_LANE0;
                end
            end
            S_LANE0, S_LANE1, S_LANE2, S_LANE3: begin
                if (byte_in.valid) begin
                    word_next.lane[lane_sel] = byte_in.data;
                    state_next = (lane_sel == LAST_LANE) ? S_WRITE
                                                         : ld_state_t'(state + 3'd1);
                end
            end
            S_WRITE: begin                          // write enable is up this cycle
                if (remain == loader_pkg::BYTE_W'(1)) begin
                    state_next = S_DONE;            // that was the last word
                end else begin
                    remain_next = remain - 1'b1;
                    addr_next   = addr + ADDR_STEP;
                    state_next  = S_LANE0;
                end
            end
            S_DONE: begin
                addr_next      = '0;                // next load starts at word 0
                word_next.word = '0;
                state_next     = S_WAIT_CNT;
            end
            default: state_next = S_WAIT_CNT;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= S_WAIT_CNT;
            remain <= '0;
            addr   <= '0;
        end else begin
            state  <= state_next;
            remain <= remain_next;
            addr   <= addr_next;
        end
    end

    always_ff @(posedge clk) begin
        word <= word_next;                          // every lane is filled before a write
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        addr_ext             = '0;                  // upper bits stay zero
        addr_ext[ADDR_W-1:0] = addr;
    end

    assign mem_wr.en   = (state == S_WRITE);
    assign mem_wr.addr = addr_ext;
    assign mem_wr.data = word;
    assign prog_rdy    = (state == S_DONE);

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 8                  // clocks per serial bit, at least 2
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 rx,                // serial line, idles high
    output loader_pkg::rx_byte_t byte_out,          // one-cycle strobe per good frame
    output logic                 frame_err          // one-cycle pulse per low stop bit
);

    localparam int CNT_W     = $clog2(CLKS_PER_BIT);
    localparam int BIT_IDX_W = $clog2(loader_pkg::BYTE_W);

    localparam logic [CNT_W-1:0]     BIT_END  = CNT_W'(CLKS_PER_BIT - 1);     // mid of next bit
    localparam logic [CNT_W-1:0]     HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1); // mid of start bit
    localparam logic [BIT_IDX_W-1:0] LAST_BIT = BIT_IDX_W'(loader_pkg::BYTE_W - 1);

    typedef enum logic [1:0] {
        S_IDLE,         // line high, watching for a falling edge
        S_START,        // half a bit into the start bit
        S_DATA,         // sampling data bits at their middle
        S_STOP          // waiting for the stop bit middle
    } rx_state_t;

    rx_state_t                      state;
    logic [1:0]                     rx_sync;        // two-flop synchronizer
    logic                           rx_s;           // synchronized line
    logic                           rx_d;           // rx_s one clock later
    logic                           start_edge;
    logic                           half_bit;
    logic                           mid_bit;
    logic [CNT_W-1:0]               clk_cnt;        // clocks within the current bit
    logic [BIT_IDX_W-1:0]           bit_idx;        // data bit being sampled
    logic [loader_pkg::BYTE_W-1:0]  shreg;          // byte under assembly, lsb first
    logic                           byte_vld;

    ////////////////////////////////////////////////////////////////////////////
    // input synchronizer and start edge
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= 2'b11;                       // line idles high
            rx_d    <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_d    <= rx_sync[1];
        end
    end

    assign rx_s       = rx_sync[1];
    assign start_edge = rx_d & ~rx_s;               // high to low on the line
    assign half_bit   = (clk_cnt == HALF_END);
    assign mid_bit    = (clk_cnt == BIT_END);

    ////////////////////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            byte_vld  <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            byte_vld  <= 1'b0;                      // strobes last one cycle
            frame_err <= 1'b0;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (start_edge) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (half_bit) begin
                        clk_cnt <= '0;
                        // still low at half a bit means a real start bit
                        state   <= rx_s ? S_IDLE : S_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (mid_bit) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            state <= S_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                S_STOP: begin
                    if (mid_bit) begin
                        byte_vld  <= rx_s;          // good stop bit
                        frame_err <= ~rx_s;         // low stop bit, byte dropped
                        clk_cnt   <= '0;
                        state     <= S_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // data bits arrive lsb first, so shift in at the top
    always_ff @(posedge clk) begin
        if (state == S_DATA && mid_bit) begin
            shreg <= {rx_s, shreg[loader_pkg::BYTE_W-1:1]};
        end
    end

    assign byte_out.valid = byte_vld;
    assign byte_out.data  = shreg;                  // stable until the next frame's first bit

endmodule

`default_nettype wire

// File: hdl/loader_pkg.sv
`default_nettype none

package loader_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int BYTE_W         = 8;     // one serial byte
    localparam int WORD_W         = 32;    // one instruction
    localparam int BYTES_PER_WORD = 4;     // bytes gathered per instruction
    localparam int ADDR_W_MAX     = 10;    // widest byte address the write struct carries

    ////////////////////////////////////////////////////////////////////////////
    // bundled signals
    ////////////////////////////////////////////////////////////////////////////

    // received byte, meaningful only on the cycle valid is high
    typedef struct packed {
        logic              valid;
        logic [BYTE_W-1:0] data;
    } rx_byte_t;

    // instruction word as the loader fills it (byte lanes, lane 0 = lsb)
    // and as the memory stores it (one flat word)
    typedef union packed {
        logic [BYTES_PER_WORD-1:0][BYTE_W-1:0] lane;
        logic [WORD_W-1:0]                     word;
    } instr_word_u;

    // one memory write; addr is a byte address, upper unused bits stay zero
    typedef struct packed {
        logic                  en;
        logic [ADDR_W_MAX-1:0] addr;
        instr_word_u           data;
    } mem_wr_t;

endpackage

`default_nettype wire
